/* design/binCountIf.sv */
`include "peakHist_settings.svh"

// updated bin counts from memory to tracker, valid only
interface binCountIf;
    import peakHistPkg::*;

    logic cntValid;
    pixelIndex_t cntPixel;
    binIndex_t cntBin;
    // count after this update
    binCount_t cntCount;
    logic cntPass;
    // separate strobe, also seen with cntValid low
    logic cntLast;

    modport sender (
        output cntValid, cntPixel, cntBin, cntCount, cntPass, cntLast
    );
    modport receiver (
        input cntValid, cntPixel, cntBin, cntCount, cntPass, cntLast
    );
endinterface

/* design/binUpdateIf.sv */
`include "peakHist_settings.svh"

// bin updates from binner to memory, valid only
interface binUpdateIf;
    import peakHistPkg::*;

    // sample was binned
    logic updValid;
    pixelIndex_t updPixel;
    binIndex_t updBin;
    // 0 coarse, 1 fine
    logic updPass;
    // final sample of a pass, may come without a count
    logic updLast;

    modport sender (
        output updValid, updPixel, updBin, updPass, updLast
    );
    modport receiver (
        input updValid, updPixel, updBin, updPass, updLast
    );
endinterface

/* design/histogramMemory.sv */
`include "peakHist_settings.svh"

module histogramMemory (
    input logic clk,
    input logic combin_res,
    binUpdateIf.receiver upd,
    binCountIf.sender cnt
);
    import peakHistPkg::*;

    localparam int depth = `PIXEL_NUM * `BIN_NUM;

    typedef logic [$clog2(depth)-1:0] binAddr_t;

    // counters per pixel and bin
    binCount_t counters [depth];
    // bin touched in this pass, stale counts are ignored
    logic [depth-1:0] binSeen;
    binAddr_t addr;
    binCount_t oldCount, newCount;

    assign addr = {upd.updPixel, upd.updBin};
    assign oldCount = counters[addr];

    // read-modify-write, saturating at full count
    always_comb begin
        if (!binSeen[addr]) begin
            newCount = binCount_t'(1);
        end else if (oldCount == '1) begin
            newCount = oldCount;
        end else begin
            newCount = oldCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.updValid) begin
            counters[addr] <= newCount;
        end
        // last marker carries the pass even without a count
        if (upd.updValid || upd.updLast) begin
            cnt.cntPixel <= upd.updPixel;
            cnt.cntBin <= upd.updBin;
            cnt.cntCount <= newCount;
            cnt.cntPass <= upd.updPass;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binSeen <= '0;
            cnt.cntValid <= 1'b0;
            cnt.cntLast <= 1'b0;
        end else begin
            cnt.cntValid <= upd.updValid;
            cnt.cntLast <= upd.updLast;
            // pass end clears the histogram in one cycle
            if (upd.updLast) begin
                binSeen <= '0;
            end else if (upd.updValid) begin
                binSeen[addr] <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!combin_res)
        upd.updValid |-> int'(upd.updPixel) < `PIXEL_NUM);

endmodule

/* design/peakHistPkg.sv */
`include "peakHist_settings.svh"

package peakHistPkg;

    // sample split into coarse bin and position inside it
    typedef struct packed {
        logic [`BIN_WIDTH-1:0] coarseBin;
        logic [`SAMPLE_WIDTH-`BIN_WIDTH-1:0] binOffset;
    } coarseView_t;

    // raw view for the window test in the fine pass
    // coarse view for bin selection in the coarse pass
    typedef union packed {
        logic [`SAMPLE_WIDTH-1:0] raw;
        coarseView_t coarse;
    } sampleWord_t;

    // coarse or fine bin number
    typedef logic [`BIN_WIDTH-1:0] binIndex_t;

    // pixel number in sample order
    typedef logic [$clog2(`PIXEL_NUM)-1:0] pixelIndex_t;

    // one bin counter
    typedef logic [`COUNT_WIDTH-1:0] binCount_t;

endpackage

/* design/peakHistTop.sv */
`include "peakHist_settings.svh"

module peakHistTop (
    input  logic clk,
    input  logic combin_res,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  peakHistPkg::sampleWord_t wbDatIn,
    output logic wbAck,
    output logic histPass,
    output logic countValid,
    output peakHistPkg::pixelIndex_t countPixel,
    output peakHistPkg::binIndex_t countBin,
    output peakHistPkg::binCount_t countValue,
    output logic resultValid,
    output peakHistPkg::pixelIndex_t resultPixel,
    output peakHistPkg::binIndex_t resultCoarseBin,
    output peakHistPkg::binIndex_t resultFineBin
);
    import peakHistPkg::*;

    // coarse peaks fed back to the window logic
    binIndex_t [`PIXEL_NUM-1:0] coarsePeaks;
    logic peaksReady;

    binUpdateIf updIf ();
    binCountIf cntIf ();

    sampleBinner binner_i (.clk, .combin_res, .wbCyc, .wbStb, .wbWe, .wbDatIn, .wbAck,
        .histPass, .coarsePeaks, .peaksReady, .upd(updIf));

    histogramMemory memory_i (.clk, .combin_res, .upd(updIf), .cnt(cntIf));

    peakTracker tracker_i (.clk, .combin_res, .cnt(cntIf), .coarsePeaks, .peaksReady,
        .resultValid, .resultPixel, .resultCoarseBin, .resultFineBin);

    // count stream out of the memory stage
    assign countValid = cntIf.cntValid;
    assign countPixel = cntIf.cntPixel;
    assign countBin = cntIf.cntBin;
    assign countValue = cntIf.cntCount;

endmodule

/* design/peakHist_settings.svh */
`ifndef PEAKHIST_SETTINGS_SVH
`define PEAKHIST_SETTINGS_SVH

// width of one sample word
`define SAMPLE_WIDTH 12
// bins per histogram, coarse and fine alike
`define BIN_WIDTH 4
`define BIN_NUM (1 << `BIN_WIDTH)
// bin counter, saturating
`define COUNT_WIDTH 8
// pixel array and sample order within a pass
`define PIXEL_NUM 4
`define SAMPLES_PER_PIXEL 2
`define ACQ_NUM 3
// log2 of fine bin width, window is 2 coarse bins wide
`define FINE_SHIFT 5
`endif

/* design/peakTracker.sv */
`include "peakHist_settings.svh"

module peakTracker (
    input  logic clk,
    input  logic combin_res,
    binCountIf.receiver cnt,
    output peakHistPkg::binIndex_t [`PIXEL_NUM-1:0] coarsePeaks,
    output logic peaksReady,
    output logic resultValid,
    output peakHistPkg::pixelIndex_t resultPixel,
    output peakHistPkg::binIndex_t resultCoarseBin,
    output peakHistPkg::binIndex_t resultFineBin
);
    import peakHistPkg::*;

    // running maximum per pixel for the current pass
    binCount_t [`PIXEL_NUM-1:0] maxCount, nextCount;
    binIndex_t [`PIXEL_NUM-1:0] maxBin, nextBin;
    logic isGreater;
    logic streamDone;

    // strictly greater, first bin at the maximum stays
    assign isGreater = cnt.cntValid && (cnt.cntCount > maxCount[cnt.cntPixel]);

    always_comb begin
        nextCount = maxCount;
        nextBin = maxBin;
        if (isGreater) begin
            nextCount[cnt.cntPixel] = cnt.cntCount;
            nextBin[cnt.cntPixel] = cnt.cntBin;
        end
    end

    assign streamDone = resultValid && (resultPixel == pixelIndex_t'(`PIXEL_NUM - 1));

    // fine peaks are read straight from the maxima while streaming
    assign resultCoarseBin = coarsePeaks[resultPixel];
    assign resultFineBin = maxBin[resultPixel];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            maxCount <= '0;
            maxBin <= '0;
            coarsePeaks <= '0;
            peaksReady <= 1'b0;
            resultValid <= 1'b0;
            resultPixel <= '0;
        end else begin
            peaksReady <= 1'b0;
            if (cnt.cntLast && !cnt.cntPass) begin
                // coarse end, latch including the final count
                coarsePeaks <= nextBin;
                maxCount <= '0;
                maxBin <= '0;
                peaksReady <= 1'b1;
            end else if (streamDone) begin
                // last result out, ready for next frame
                maxCount <= '0;
                maxBin <= '0;
                resultValid <= 1'b0;
                resultPixel <= '0;
                peaksReady <= 1'b1;
            end else begin
                maxCount <= nextCount;
                maxBin <= nextBin;
                // fine end, stream from pixel 0
                if (cnt.cntLast) begin
                    resultValid <= 1'b1;
                    resultPixel <= '0;
                end else if (resultValid) begin
                    resultPixel <= resultPixel + 1'b1;
                end
            end
        end
    end

    // binner holds off new samples until streaming is over
    assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |-> !cnt.cntValid);

endmodule

/* design/sampleBinner.sv */
`include "peakHist_settings.svh"

module sampleBinner (
    input  logic clk,
    input  logic combin_res,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  peakHistPkg::sampleWord_t wbDatIn,
    output logic wbAck,
    output logic histPass,
    input  peakHistPkg::binIndex_t [`PIXEL_NUM-1:0] coarsePeaks,
    input  logic peaksReady,
    binUpdateIf.sender upd
);
    import peakHistPkg::*;

    localparam int sampleCntWidth = $clog2(`SAMPLES_PER_PIXEL);
    localparam int acqCntWidth = $clog2(`ACQ_NUM);
    localparam int coarseWidth = 1 << (`SAMPLE_WIDTH - `BIN_WIDTH);
    localparam int windowSpan = `BIN_NUM << `FINE_SHIFT;

    // one extra bit so the window end at full scale fits
    typedef logic [`SAMPLE_WIDTH:0] sampleExt_t;
    localparam sampleExt_t halfBin = sampleExt_t'(coarseWidth / 2);
    localparam sampleExt_t spanExt = sampleExt_t'(windowSpan);
    localparam sampleExt_t lowerMax = sampleExt_t'((1 << `SAMPLE_WIDTH) - windowSpan);

    logic [sampleCntWidth-1:0] sampleCnt;
    pixelIndex_t pixelCnt;
    logic [acqCntWidth-1:0] acqCnt;
    logic waiting;
    logic accept;
    logic sampleWrap, pixelWrap, acqWrap, lastSample;
    binIndex_t peakBin, fineBin;
    sampleExt_t lowerBound, sampleExt, offset;
    logic inWindow;

    // classic write, one ack cycle per sample
    assign accept = wbCyc && wbStb && wbWe && !wbAck && !waiting;

    assign sampleWrap = sampleCnt == sampleCntWidth'(`SAMPLES_PER_PIXEL - 1);
    assign pixelWrap = pixelCnt == pixelIndex_t'(`PIXEL_NUM - 1);
    assign acqWrap = acqCnt == acqCntWidth'(`ACQ_NUM - 1);
    assign lastSample = sampleWrap && pixelWrap && acqWrap;

    // window lower bound from this pixel's coarse peak
    assign peakBin = coarsePeaks[pixelCnt];
    always_comb begin
        if (peakBin == '0) begin
            lowerBound = '0;
        end else if (peakBin == '1) begin
            lowerBound = lowerMax;
        end else begin
            lowerBound = {1'b0, peakBin, {(`SAMPLE_WIDTH - `BIN_WIDTH){1'b0}}} - halfBin;
        end
    end

    // raw view for the window test
    assign sampleExt = {1'b0, wbDatIn.raw};
    assign inWindow = (sampleExt >= lowerBound) && (sampleExt < lowerBound + spanExt);
    assign offset = sampleExt - lowerBound;
    assign fineBin = offset[`FINE_SHIFT +: `BIN_WIDTH];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wbAck <= 1'b0;
            histPass <= 1'b0;
            waiting <= 1'b0;
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
            upd.updValid <= 1'b0;
            upd.updLast <= 1'b0;
        end else begin
            wbAck <= accept;
            // out of window samples are acked but not binned
            upd.updValid <= accept && (!histPass || inWindow);
            upd.updLast <= accept && lastSample;
            if (accept) begin
                sampleCnt <= sampleWrap ? '0 : sampleCnt + 1'b1;
                if (sampleWrap) begin
                    pixelCnt <= pixelCnt + 1'b1;
                    if (pixelWrap) begin
                        acqCnt <= acqWrap ? '0 : acqCnt + 1'b1;
                    end
                end
                // pass end, hold off until tracker is done
                if (lastSample) begin
                    histPass <= !histPass;
                    waiting <= 1'b1;
                end
            end else if (peaksReady) begin
                waiting <= 1'b0;
            end
        end
    end

    // update payload
    always_ff @(posedge clk) begin
        if (accept) begin
            upd.updPixel <= pixelCnt;
            upd.updBin <= histPass ? fineBin : wbDatIn.coarse.coarseBin;
            upd.updPass <= histPass;
        end
    end

    // only the ack of the final sample may follow once waiting
    assert property (@(posedge clk) disable iff (!combin_res)
        waiting && $past(waiting) |-> !wbAck);

endmodule

/* flist.f */
+incdir+design
design/peakHistPkg.sv
design/binUpdateIf.sv
design/binCountIf.sv
design/sampleBinner.sv
design/histogramMemory.sv
design/peakTracker.sv
design/peakHistTop.sv
testbench/peakHistTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module peakHistTb -f flist.f -o peakHistSim

simOut=$(./obj_dir/peakHistSim)
echo "$simOut"

if echo "$simOut" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi

/* testbench/peakHistTb.sv */
`include "peakHist_settings.svh"

module peakHistTb;
    timeunit 1ns;
    timeprecision 100ps;
    import peakHistPkg::*;

    localparam int passLen = `ACQ_NUM * `PIXEL_NUM * `SAMPLES_PER_PIXEL;
    localparam int timeoutLimit = 2 * passLen * 4 + 200;

    logic clk, combin_res, wbCyc, wbStb, wbWe, wbAck, histPass;
    sampleWord_t wbDatIn;
    logic countValid, resultValid;
    pixelIndex_t countPixel, resultPixel;
    binIndex_t countBin, resultCoarseBin, resultFineBin;
    binCount_t countValue;

    int seed = 49;
    int cycles = 0;
    int resultCount = 0;
    int errByTest [6];
    // sample in flight, set when it is driven
    logic curBinned, curPass, curFirst;
    pixelIndex_t curPixel;
    binIndex_t curBin;
    binCount_t curCount;
    int curFrame;
    // copy of the acked sample, valid while its count comes out
    logic chkPass;
    pixelIndex_t chkPixel;
    binIndex_t chkBin;
    binCount_t chkCount;
    int chkFrame;
    // reference histogram
    int modelCnt [`PIXEL_NUM][`BIN_NUM];
    int modelMax [`PIXEL_NUM];
    binIndex_t modelPeak [`PIXEL_NUM];
    binIndex_t expCoarse [`PIXEL_NUM];
    binIndex_t expFine [`PIXEL_NUM];
    int lowBound [`PIXEL_NUM];
    binIndex_t target [`PIXEL_NUM];

    peakHistTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = !clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (resultValid) resultCount <= resultCount + 1;
        if (wbAck) begin
            chkPass <= curPass;
            chkPixel <= curPixel;
            chkBin <= curBin;
            chkCount <= curCount;
            chkFrame <= curFrame;
        end
        if (cycles == timeoutLimit) begin
            $display("timeout: run still busy after %0d cycles", timeoutLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    // which behavior a count belongs to
    function automatic int countTest();
        if (chkFrame > 0) return 5;
        if (!chkPass) return 1;
        return (int'(chkPixel) < 2) ? 3 : 2;
    endfunction

    // window lower bound, clamped at both ends
    function automatic int windowLow(binIndex_t peak);
        if (peak == 0) return 0;
        if (peak == 15) return 4096 - 512;
        return int'(peak) * 256 - 128;
    endfunction

    // reset and ack rules
    assert property (@(posedge clk) !combin_res |=> !wbAck && !countValid && !resultValid
        && !histPass) else begin
        errByTest[0]++;
        $display("reset left outputs active");
    end
    assert property (@(posedge clk) disable iff (!combin_res) wbAck |=> !wbAck)
        else begin
        errByTest[0]++;
        $display("wbAck lasted longer than one cycle");
    end
    assert property (@(posedge clk) disable iff (!combin_res)
        wbAck |-> $past(wbCyc && wbStb && wbWe && !wbAck))
        else begin
        errByTest[0]++;
        $display("wbAck without a write request");
    end
    assert property (@(posedge clk) disable iff (!combin_res)
        wbStb && !wbAck |-> histPass == curPass) else begin
        errByTest[curFrame > 0 ? 5 : 0]++;
        $display("error histPass expected %h got %h", curPass, $sampled(histPass));
    end

    // count stream
    assert property (@(posedge clk) disable iff (!combin_res)
        wbAck && curBinned |=> countValid)
        else begin
        errByTest[countTest()]++;
        $display("binned sample gave no count");
    end
    assert property (@(posedge clk) disable iff (!combin_res)
        wbAck && !curBinned |=> !countValid)
        else begin
        errByTest[2]++;
        $display("out of window sample gave a count");
    end
    assert property (@(posedge clk) disable iff (!combin_res)
        countValid |-> countPixel == chkPixel) else begin
        errByTest[countTest()]++;
        $display("error countPixel expected %h got %h", chkPixel, $sampled(countPixel));
    end
    assert property (@(posedge clk) disable iff (!combin_res)
        countValid |-> countBin == chkBin) else begin
        errByTest[countTest()]++;
        $display("error countBin expected %h got %h", chkBin, $sampled(countBin));
    end
    assert property (@(posedge clk) disable iff (!combin_res)
        countValid |-> countValue == chkCount) else begin
        errByTest[countTest()]++;
        $display("error countValue expected %h got %h", chkCount, $sampled(countValue));
    end

    // result stream and hold off
    assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |-> resultPixel == pixelIndex_t'(resultCount % `PIXEL_NUM))
        else begin
        errByTest[4]++;
        $display("error resultPixel expected %h got %h",
            pixelIndex_t'($sampled(resultCount) % `PIXEL_NUM), $sampled(resultPixel));
    end
    assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |-> resultCoarseBin == expCoarse[resultPixel])
        else begin
        errByTest[4]++;
        $display("error resultCoarseBin expected %h got %h",
            expCoarse[$sampled(resultPixel)], $sampled(resultCoarseBin));
    end
    assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |-> resultFineBin == expFine[resultPixel])
        else begin
        errByTest[4]++;
        $display("error resultFineBin expected %h got %h",
            expFine[$sampled(resultPixel)], $sampled(resultFineBin));
    end
    assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |-> !wbAck ##1 !wbAck)
        else begin
        errByTest[4]++;
        $display("sample acked while results streamed");
    end
    assert property (@(posedge clk) disable iff (!combin_res)
        wbAck && curFirst && !curPass |-> resultCount == `PIXEL_NUM * curFrame)
        else begin
        errByTest[4]++;
        $display("new frame started before results were out");
    end

    // one Wishbone write, with the model's expectation for it
    task automatic writeSample(input logic [11:0] value, input logic binned,
            input int pixel, input int bin, input int count, input logic pass,
            input logic first, input int frame);
        @(posedge clk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe <= 1'b1;
        wbDatIn <= value;
        curBinned <= binned;
        curPixel <= pixelIndex_t'(pixel);
        curBin <= binIndex_t'(bin);
        curCount <= binCount_t'(count);
        curPass <= pass;
        curFirst <= first;
        curFrame <= frame;
        @(negedge clk);
        while (!wbAck) @(negedge clk);
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe <= 1'b0;
    endtask

    // one pass in sample order, peaks shaped per pixel
    task automatic runPass(input logic pass, input int frame);
        int value, bin, count;
        logic binned;
        foreach (modelCnt[p, b]) modelCnt[p][b] = 0;
        foreach (modelMax[p]) modelMax[p] = 0;
        foreach (modelPeak[p]) modelPeak[p] = '0;
        for (int a = 0; a < `ACQ_NUM; a++) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                for (int s = 0; s < `SAMPLES_PER_PIXEL; s++) begin
                    if (($random(seed) & 3) == 0 && (pass || p >= 2)) begin
                        value = $random(seed) & 12'hfff;
                    end else if (!pass) begin
                        value = int'(target[p]) * 256 + ($random(seed) & 8'hff);
                    end else begin
                        value = lowBound[p] + ($random(seed) & 9'h1ff);
                    end
                    binned = !pass || (value >= lowBound[p] && value < lowBound[p] + 512);
                    bin = pass ? ((value - lowBound[p]) >> `FINE_SHIFT) : (value >> 8);
                    count = 0;
                    if (binned) begin
                        if (modelCnt[p][bin] < 255) modelCnt[p][bin]++;
                        count = modelCnt[p][bin];
                        // first bin to reach the maximum keeps it
                        if (count > modelMax[p]) begin
                            modelMax[p] = count;
                            modelPeak[p] = binIndex_t'(bin);
                        end
                    end
                    writeSample(12'(value), binned, p, bin, count, pass,
                        a == 0 && p == 0 && s == 0, frame);
                end
            end
        end
        foreach (modelPeak[p]) begin
            if (!pass) begin
                expCoarse[p] = modelPeak[p];
                lowBound[p] = windowLow(modelPeak[p]);
            end else begin
                expFine[p] = modelPeak[p];
            end
        end
    endtask

    initial begin
        int total;
        combin_res = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbDatIn = '0;
        {curBinned, curPass, curFirst, curPixel, curBin, curCount, curFrame} = '0;
        // pixel 0 and 1 pinned to the clamped ends
        target[0] = 4'd0;
        target[1] = 4'd15;
        target[2] = binIndex_t'(1 + ($random(seed) & 7));
        target[3] = binIndex_t'(6 + ($random(seed) & 7));
        repeat (16) @(posedge clk);
        combin_res <= 1'b1;
        // next frame is requested while the results still stream
        for (int f = 0; f < 2; f++) begin
            runPass(1'b0, f);
            if (f == 0) begin
                $display("test 1 reset and ack: %0d errors", errByTest[0]);
                $display("test 2 coarse counts: %0d errors", errByTest[1]);
            end
            runPass(1'b1, f);
            if (f == 0) begin
                $display("test 3 fine window counts: %0d errors", errByTest[2]);
                $display("test 4 clamped windows: %0d errors", errByTest[3]);
            end
        end
        wait (resultCount == 2 * `PIXEL_NUM);
        $display("test 5 result stream: %0d errors", errByTest[4]);
        repeat (4) @(posedge clk);
        $display("test 6 second frame: %0d errors", errByTest[5]);
        total = errByTest.sum();
        $display("6 tests run, %0d results seen, %0d errors", resultCount, total);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
